// ==== Makefile ====
# Verilator build and run for the 5x5 window generator

VERILATOR ?= verilator
TOP       ?= tb_conv_window
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

BIN     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FLIST))

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FLIST OBJ_DIR LOG VFLAGS"

$(BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

test: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "RESULT: PASS" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== conv_window_top.sv ====
// Top level of the 5x5 window generator, joins loader, line ring and sequencer
module conv_window_top
    import win_geom_pkg::*;
    import win_stream_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,
    input  logic      i_start,
    input  logic      i_pixel_valid,
    input  pixel_t    i_pixel,
    input  logic      i_win_ready,
    output logic      o_pixel_ready,
    output logic      o_win_valid,
    output win_beat_t o_win,
    output logic      o_done
);

    line_wr_t line_wr;
    row_cnt_t rows_loaded;   // Loader progress
    row_cnt_t out_row;       // Oldest input row still needed
    slot_t    rd_base;
    col_t     rd_col;
    window_t  window;

    pixel_loader pixel_loader_i (
        .clk           (clk),
        .reset_n       (reset_n),
        .i_start       (i_start),
        .i_pixel_valid (i_pixel_valid),
        .i_pixel       (i_pixel),
        .i_out_row     (out_row),
        .o_pixel_ready (o_pixel_ready),
        .o_line_wr     (line_wr),
        .o_rows_loaded (rows_loaded)
    );

    line_ring_buffer line_ring_buffer_i (
        .clk       (clk),
        .i_line_wr (line_wr),
        .i_rd_base (rd_base),
        .i_rd_col  (rd_col),
        .o_window  (window)
    );

    window_sequencer window_sequencer_i (
        .clk           (clk),
        .reset_n       (reset_n),
        .i_start       (i_start),
        .i_rows_loaded (rows_loaded),
        .i_window      (window),
        .i_win_ready   (i_win_ready),
        .o_rd_base     (rd_base),
        .o_rd_col      (rd_col),
        .o_out_row     (out_row),
        .o_win_valid   (o_win_valid),
        .o_win         (o_win),
        .o_done        (o_done)
    );

endmodule

// ==== flist.f ====
win_geom_pkg.sv
win_stream_pkg.sv
pixel_loader.sv
line_ring_buffer.sv
window_sequencer.sv
conv_window_top.sv
tb_clock_gen.sv
tb_conv_window.sv

// ==== line_ring_buffer.sv ====
// Six line pixel store with one write port and a combinational 5x5 window read
module line_ring_buffer
    import win_geom_pkg::*;
    import win_stream_pkg::*;
(
    input  logic     clk,
    input  line_wr_t i_line_wr,
    input  slot_t    i_rd_base,
    input  col_t     i_rd_col,
    output window_t  o_window
);

    pixel_t mem [NUM_LINES][IMG_W];

    slot_t row_slot [KERNEL];   // Ring slot of each window row
    col_t  col_idx  [KERNEL];   // Line column of each window column

    // Slot a fixed distance past the base, modulo the ring size
    function automatic slot_t slot_add(slot_t base, int unsigned off);
        int unsigned sum;
        sum = base + off;
        if (sum >= NUM_LINES) begin
            sum = sum - NUM_LINES;
        end
        return slot_t'(sum);
    endfunction

    // Write side, one pixel per edge
    always_ff @(posedge clk) begin
        if (i_line_wr.en) begin
            mem[i_line_wr.slot][i_line_wr.col] <= i_line_wr.pixel;
        end
    end

    always_comb begin
        for (int r = 0; r < KERNEL; r++) begin
            row_slot[r] = slot_add(i_rd_base, r);
        end
        for (int c = 0; c < KERNEL; c++) begin
            // Highest start column is OUT_W-1, so this never passes IMG_W-1
            col_idx[c] = i_rd_col + col_t'(c);
        end
    end

    // Window gather, pixels reinterpreted as signed samples
    always_comb begin
        for (int r = 0; r < KERNEL; r++) begin
            for (int c = 0; c < KERNEL; c++) begin
                o_window[r][c] = sample_t'(mem[row_slot[r]][col_idx[c]]);
            end
        end
    end

endmodule

// ==== pixel_loader.sv ====
// Input side of the window generator, takes raster pixels and fills the line ring
module pixel_loader
    import win_geom_pkg::*;
    import win_stream_pkg::*;
(
    input  logic     clk,
    input  logic     reset_n,
    input  logic     i_start,
    input  logic     i_pixel_valid,
    input  pixel_t   i_pixel,
    input  row_cnt_t i_out_row,
    output logic     o_pixel_ready,
    output line_wr_t o_line_wr,
    output row_cnt_t o_rows_loaded
);

    logic     active;       // Frame in progress, rows still to load
    col_t     wr_col;
    slot_t    wr_slot;
    row_cnt_t rows_loaded;  // Also the index of the row being written
    logic     accept;
    logic     last_col;
    logic     row_free;

    // Row r may go in while r <= out_row + KERNEL
    // Its slot then belongs to a row no output row still needs
    assign row_free = (rows_loaded <= i_out_row + row_cnt_t'(KERNEL));

    assign o_pixel_ready = active && row_free;
    assign accept        = i_pixel_valid && o_pixel_ready;
    assign last_col      = (wr_col == col_t'(IMG_W - 1));

    always_comb begin
        o_line_wr.en    = accept;
        o_line_wr.slot  = wr_slot;
        o_line_wr.col   = wr_col;
        o_line_wr.pixel = i_pixel;
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            active      <= 1'b0;
            wr_col      <= '0;
            wr_slot     <= '0;
            rows_loaded <= '0;
        end else if (!active && i_start) begin
            active      <= 1'b1;
            wr_col      <= '0;
            wr_slot     <= '0;
            rows_loaded <= '0;
        end else if (accept) begin
            if (last_col) begin
                wr_col      <= '0;
                rows_loaded <= rows_loaded + 1'b1;

                // Ring wraps at six slots
                if (wr_slot == slot_t'(NUM_LINES - 1)) begin
                    wr_slot <= '0;
                end else begin
                    wr_slot <= wr_slot + 1'b1;
                end

                if (rows_loaded == row_cnt_t'(IMG_H - 1)) begin
                    active <= 1'b0;     // Whole frame in
                end
            end else begin
                wr_col <= wr_col + 1'b1;
            end
        end
    end

    assign o_rows_loaded = rows_loaded;

endmodule

// ==== tb_clock_gen.sv ====
// Testbench clock and reset source, 8 ns clock with reset held low for the first cycles
module tb_clock_gen (
    output logic clk,
    output logic reset_n
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_PERIOD  = 4;    // 8 ns clock
    localparam int RESET_CYCLES = 10;

    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

    // Synchronous reset, released just after an edge
    initial begin
        reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset_n = 1'b1;
    end

endmodule

// ==== tb_conv_window.sv ====
// Testbench for the 5x5 window generator that checks window data, order, stalls and done
module tb_conv_window
    import win_geom_pkg::*;
    import win_stream_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_FRAMES     = 2;
    localparam int PIXELS         = IMG_W * IMG_H;
    localparam int NUM_WINDOWS    = OUT_W * OUT_H;
    localparam int HOLD_CYCLES    = 500;                     // Long stall in frame one
    localparam int HOLD_PIX_LIMIT = (KERNEL + 1) * IMG_W;    // Rows 0 to 5 with output row 0
    localparam int TIMEOUT_CYCLES = NUM_FRAMES * 10 * PIXELS;

    logic      clk;
    logic      reset_n;
    logic      i_start;
    logic      i_pixel_valid;
    pixel_t    i_pixel;
    logic      i_win_ready;
    logic      o_pixel_ready;
    logic      o_win_valid;
    win_beat_t o_win;
    logic      o_done;

    integer  seed;
    int      cycle_count = 0;
    pixel_t  frame_img [IMG_H][IMG_W];   // Frame as sent

    int      exp_row;       // Position of the next expected window
    int      exp_col;
    int      win_count;
    int      pix_count;
    logic    done_due;      // Last window left on the previous edge
    logic    started;
    logic    hold_phase;
    logic    win_xfer;
    logic    pix_xfer;
    window_t exp_win;

    tb_clock_gen tb_clock_gen_i (
        .clk     (clk),
        .reset_n (reset_n)
    );

    conv_window_top conv_window_top_i (
        .clk           (clk),
        .reset_n       (reset_n),
        .i_start       (i_start),
        .i_pixel_valid (i_pixel_valid),
        .i_pixel       (i_pixel),
        .i_win_ready   (i_win_ready),
        .o_pixel_ready (o_pixel_ready),
        .o_win_valid   (o_win_valid),
        .o_win         (o_win),
        .o_done        (o_done)
    );

    // Window (r,c) element (i,j) is input pixel (r+i, c+j) read as signed
    function automatic window_t expected_window(int r, int c);
        window_t w;
        w = '0;
        if (r < OUT_H && c < OUT_W) begin
            for (int i = 0; i < KERNEL; i++) begin
                for (int j = 0; j < KERNEL; j++) begin
                    w[i][j] = sample_t'(frame_img[r + i][c + j]);
                end
            end
        end
        return w;
    endfunction

    task automatic fail_value(input string msg);
        $display("ERROR at %0d ns: %s", $time, msg);
        $display("RESULT: FAIL");
        $fatal(1, "Stopped at first error");
    endtask

    assign win_xfer = o_win_valid && i_win_ready;
    assign pix_xfer = i_pixel_valid && o_pixel_ready;

    always_comb begin
        exp_win = expected_window(exp_row, exp_col);
    end

    // Raster position and transfer counts seen at the ports
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            exp_row   <= 0;
            exp_col   <= 0;
            win_count <= 0;
            pix_count <= 0;
            done_due  <= 1'b0;
            started   <= 1'b0;
        end else begin
            done_due <= win_xfer && (win_count == NUM_WINDOWS - 1);
            if (i_start) begin
                started   <= 1'b1;
                exp_row   <= 0;
                exp_col   <= 0;
                win_count <= 0;
                pix_count <= 0;
            end else begin
                if (pix_xfer) begin
                    pix_count <= pix_count + 1;
                end
                if (win_xfer) begin
                    win_count <= win_count + 1;
                    if (exp_col == OUT_W - 1) begin
                        exp_col <= 0;
                        exp_row <= exp_row + 1;
                    end else begin
                        exp_col <= exp_col + 1;
                    end
                end
            end
        end
    end

    window_data: assert property (@(posedge clk) disable iff (!reset_n)
        win_xfer |-> (o_win.win == exp_win))
        else fail_value($sformatf("window (%0d,%0d) differs from the sent frame",
                                  $sampled(exp_row), $sampled(exp_col)));

    row_flags: assert property (@(posedge clk) disable iff (!reset_n)
        win_xfer |-> ((o_win.row_start == (exp_col == 0))
                  && (o_win.row_end == (exp_col == OUT_W - 1))))
        else fail_value($sformatf("row flags wrong at window (%0d,%0d)",
                                  $sampled(exp_row), $sampled(exp_col)));

    window_count: assert property (@(posedge clk) disable iff (!reset_n)
        win_xfer |-> (win_count < NUM_WINDOWS))
        else fail_value("more windows than positions in one frame");

    // Stalled beat must not move
    beat_hold: assert property (@(posedge clk) disable iff (!reset_n)
        (o_win_valid && !i_win_ready) |=> (o_win_valid && $stable(o_win)))
        else fail_value("window beat changed while stalled");

    pixel_limit: assert property (@(posedge clk) disable iff (!reset_n)
        hold_phase |-> (pix_count <= HOLD_PIX_LIMIT))
        else fail_value($sformatf("loader took %0d pixels during the stall",
                                  $sampled(pix_count)));

    idle_outputs: assert property (@(posedge clk) disable iff (!reset_n)
        !started |-> (!o_pixel_ready && !o_win_valid && !o_done))
        else fail_value("output active before the first start");

    // One cycle pulse right after the final transfer
    done_pulse: assert property (@(posedge clk) disable iff (!reset_n)
        o_done == done_due)
        else fail_value($sformatf("done is %0b, expected %0b",
                                  $sampled(o_done), $sampled(done_due)));

    task automatic make_frame();
        for (int r = 0; r < IMG_H; r++) begin
            for (int c = 0; c < IMG_W; c++) begin
                frame_img[r][c] = pixel_t'($random(seed));
            end
        end
    endtask

    // Called 1 ns after an edge
    task automatic start_frame();
        i_start = 1'b1;
        @(posedge clk);
        #1;
        i_start = 1'b0;
    endtask

    // Feeds one frame and drains its windows until done
    task automatic run_frame(input bit long_stall);
        int   idx;
        int   cyc;
        logic fire;
        logic done_seen;
        idx       = 0;
        cyc       = 0;
        done_seen = 1'b0;
        while (!done_seen) begin
            if (!i_pixel_valid && idx < PIXELS) begin
                i_pixel_valid = (($random(seed) & 3) != 0);
                i_pixel       = frame_img[idx / IMG_W][idx % IMG_W];
            end
            hold_phase = long_stall && (cyc < HOLD_CYCLES);
            if (hold_phase) begin
                i_win_ready = 1'b0;
            end else begin
                i_win_ready = (($random(seed) & 3) != 0);
            end
            @(negedge clk);     // Sample mid cycle where outputs are settled
            fire      = i_pixel_valid && o_pixel_ready;
            done_seen = o_done;
            if (long_stall && cyc == HOLD_CYCLES - 1) begin
                assert (pix_count == HOLD_PIX_LIMIT)
                    else fail_value($sformatf("stall ended with %0d pixels loaded",
                                              pix_count));
            end
            @(posedge clk);
            #1;
            if (fire) begin
                idx++;
                i_pixel_valid = 1'b0;
            end
            cyc++;
        end
        i_win_ready = 1'b1;     // Any beat after done transfers and gets counted
        hold_phase  = 1'b0;
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("RESULT: FAIL");
            $fatal(1, "Timeout");
        end
    end

    initial begin
        seed          = 93504;
        i_start       = 1'b0;
        i_pixel_valid = 1'b0;
        i_pixel       = '0;
        i_win_ready   = 1'b0;
        hold_phase    = 1'b0;

        // Idle cycles after reset so the quiet outputs get checked
        wait (reset_n === 1'b1);
        repeat (5) @(posedge clk);
        #1;

        for (int f = 0; f < NUM_FRAMES; f++) begin
            make_frame();
            start_frame();
            run_frame(f == 0);
            repeat (3) @(posedge clk);
            #1;
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule

// ==== win_geom_pkg.sv ====
// Image, kernel and line ring geometry for the 5x5 sliding window generator
package win_geom_pkg;

    // Input image
    localparam int IMG_W = 32;
    localparam int IMG_H = 32;

    // Window side
    localparam int KERNEL = 5;

    // Valid window positions, no padding
    localparam int OUT_W = IMG_W - KERNEL + 1;
    localparam int OUT_H = IMG_H - KERNEL + 1;

    // One spare slot so the next row loads while five are read
    localparam int NUM_LINES = KERNEL + 1;

    localparam int PIX_W = 8;

    // Index widths
    localparam int COL_W     = $clog2(IMG_W);
    localparam int ROW_CNT_W = $clog2(IMG_H + 1);   // Must reach IMG_H itself
    localparam int SLOT_W    = $clog2(NUM_LINES);

    // Column within a line
    typedef logic [COL_W-1:0] col_t;

    // Row count, 0 to IMG_H
    typedef logic [ROW_CNT_W-1:0] row_cnt_t;

    // Ring slot, 0 to NUM_LINES-1
    typedef logic [SLOT_W-1:0] slot_t;

endpackage

// ==== win_stream_pkg.sv ====
// Pixel, window and line write types passed between the window generator blocks
package win_stream_pkg;

    import win_geom_pkg::*;

    // Raw input pixel
    typedef logic [PIX_W-1:0] pixel_t;

    // Same bits seen as a signed sample
    typedef logic signed [PIX_W-1:0] sample_t;

    // 5x5 block, row index first
    // Element [0][0] is the top-left pixel and sits in the top bits
    typedef sample_t [0:KERNEL-1][0:KERNEL-1] window_t;

    // One output beat
    typedef struct packed {
        window_t win;
        logic    row_start;     // First window of an output row
        logic    row_end;       // Last window of an output row
    } win_beat_t;

    // Single pixel write into the line ring
    typedef struct packed {
        logic   en;
        slot_t  slot;
        col_t   col;
        pixel_t pixel;
    } line_wr_t;

endpackage

// ==== window_sequencer.sv ====
// Output side of the window generator, walks the 28x28 positions and emits window beats
module window_sequencer
    import win_geom_pkg::*;
    import win_stream_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,
    input  logic      i_start,
    input  row_cnt_t  i_rows_loaded,
    input  window_t   i_window,
    input  logic      i_win_ready,
    output slot_t     o_rd_base,
    output col_t      o_rd_col,
    output row_cnt_t  o_out_row,
    output logic      o_win_valid,
    output win_beat_t o_win,
    output logic      o_done
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_RUN,
        S_FINISH
    } state_t;

    state_t    state;
    col_t      col;         // Column of the next window to issue
    row_cnt_t  out_row;     // Output row of the next window to issue
    slot_t     rd_base;     // Ring slot holding input row out_row
    logic      win_valid;
    win_beat_t win_q;

    logic rows_ready;
    logic beat_xfer;
    logic load;
    logic last_col;
    logic last_row;

    // Output row R needs input rows R..R+4 in the ring
    assign rows_ready = (i_rows_loaded >= out_row + row_cnt_t'(KERNEL));
    assign beat_xfer  = win_valid && i_win_ready;

    // Output register free now or emptied on this edge
    assign load     = (state == S_RUN) && rows_ready && (!win_valid || i_win_ready);
    assign last_col = (col == col_t'(OUT_W - 1));
    assign last_row = (out_row == row_cnt_t'(OUT_H - 1));

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state     <= S_IDLE;
            col       <= '0;
            out_row   <= '0;
            rd_base   <= '0;
            win_valid <= 1'b0;
            o_done    <= 1'b0;
        end else begin
            o_done <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (i_start) begin
                        col     <= '0;
                        out_row <= '0;
                        rd_base <= '0;
                        state   <= S_RUN;
                    end
                end

                S_RUN: begin
                    if (load) begin
                        win_valid <= 1'b1;
                        if (last_col) begin
                            col     <= '0;
                            out_row <= out_row + 1'b1;  // Frees the oldest slot
                            if (rd_base == slot_t'(NUM_LINES - 1)) begin
                                rd_base <= '0;
                            end else begin
                                rd_base <= rd_base + 1'b1;
                            end
                            if (last_row) begin
                                state <= S_FINISH;      // Last window issued
                            end
                        end else begin
                            col <= col + 1'b1;
                        end
                    end else if (beat_xfer) begin
                        win_valid <= 1'b0;
                    end
                end

                S_FINISH: begin
                    // Wait for the final beat to leave
                    if (beat_xfer) begin
                        win_valid <= 1'b0;
                        o_done    <= 1'b1;
                        state     <= S_IDLE;
                    end
                end

                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // Beat payload, held while the consumer stalls
    always_ff @(posedge clk) begin
        if (load) begin
            win_q.win       <= i_window;
            win_q.row_start <= (col == '0);
            win_q.row_end   <= last_col;
        end
    end

    assign o_rd_base   = rd_base;
    assign o_rd_col    = col;
    assign o_out_row   = out_row;
    assign o_win_valid = win_valid;
    assign o_win       = win_q;

endmodule
